// File: include/limn_settings.svh
`ifndef LIMN_SETTINGS_SVH
`define LIMN_SETTINGS_SVH

// Data and address width
`define LIMN_XLEN 32

// General register file size
`define LIMN_NUM_REGS 32

`define LIMN_RESET_PC 32'hFFFE0000

// Link register for JAL
`define LIMN_LINK_REG 31

// Top four group bits that mark HLT in the privileged group
`define LIMN_HALT_GROUP 4'b1100

`endif

// File: logic/limn_pkg.sv
`include "limn_settings.svh"

package limn_pkg;

    typedef logic [`LIMN_XLEN-1:0] word_t;
    typedef logic [$clog2(`LIMN_NUM_REGS)-1:0] reg_idx_t;

    ////////////////////
    // Encodings

    // Codes match the op field of the immediate and register groups
    typedef enum logic [2:0] {
        op_lui  = 3'b000,
        op_or   = 3'b001,
        op_xor  = 3'b010,
        op_and  = 3'b011,
        op_slts = 3'b100,
        op_slt  = 3'b101,
        op_sub  = 3'b110,
        op_add  = 3'b111
    } alu_op_t;

    typedef enum logic [3:0] {
        kind_nop,       // Unsupported opcode that only advances pc
        kind_alu_reg,
        kind_alu_imm,
        kind_load,
        kind_store,
        kind_beq,
        kind_bne,
        kind_jal,
        kind_halt
    } instr_kind_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_execute,
        st_read,
        st_write,
        st_halted
    } core_state_t;

endpackage

// File: logic/limn_alu.sv
`timescale 1ns/1ps
`include "limn_settings.svh"

module limn_alu import limn_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   rb_val,
    input  word_t   imm16,
    input  logic    use_imm,
    output word_t   result
);

    word_t b;
    logic  signs_differ;

    assign b = use_imm ? imm16 : rb_val;
    assign signs_differ = a[`LIMN_XLEN-1] ^ b[`LIMN_XLEN-1];

    always_comb begin
        case (op)
            op_add: result = a + b;
            op_sub: result = a - b;
            op_and: result = a & b;
            op_xor: result = a ^ b;
            op_or:  result = a | b;
            op_slt: result = word_t'(a < b);  // Unsigned
            op_slts: begin
                // Negative a against positive b is always less
                if (signs_differ) begin
                    result = word_t'(a[`LIMN_XLEN-1]);
                end else begin
                    result = word_t'(a < b);
                end
            end
            // LUI merges the upper half into ra
            op_lui: result = a | (imm16 << 16);
            default: result = '0;
        endcase
    end

endmodule

// File: logic/limn_regfile.sv
`timescale 1ns/1ps
`include "limn_settings.svh"

module limn_regfile import limn_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_idx,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    output word_t    rd_val,
    output word_t    ra_val,
    output word_t    rb_val,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [`LIMN_NUM_REGS];

    // Combinational reads
    assign rd_val = regs[rd_idx];
    assign ra_val = regs[ra_idx];
    assign rb_val = regs[rb_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LIMN_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin  // r0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    ////////////////////
    // Checks

    // r0 reads zero on every port
    a_r0_zero : assert property (@(posedge clk) disable iff (rst)
        (rd_idx != '0 || rd_val == '0) &&
        (ra_idx != '0 || ra_val == '0) &&
        (rb_idx != '0 || rb_val == '0));

endmodule

// File: logic/limn_decoder.sv
`timescale 1ns/1ps
`include "limn_settings.svh"

module limn_decoder import limn_pkg::*; (
    input  word_t       instr,
    output instr_kind_t kind,
    output alu_op_t     alu_op,
    output reg_idx_t    rd,
    output reg_idx_t    ra,
    output reg_idx_t    rb,
    output word_t       imm16,
    output word_t       branch_offset,
    output word_t       jump_target,
    output logic        use_imm
);

    logic [5:0] opcode;
    logic [5:0] group;

    assign opcode = instr[5:0];
    assign group  = instr[31:26];

    ////////////////////
    // Fields

    assign rd = instr[10:6];
    assign ra = instr[15:11];
    assign rb = instr[20:16];

    assign imm16 = {16'b0, instr[31:16]};

    // Signed word count, scaled to bytes
    assign branch_offset = {{9{instr[31]}}, instr[31:11], 2'b00};
    assign jump_target   = {1'b0, instr[31:3], 2'b00};  // Top bit comes from pc

    ////////////////////
    // Classification

    always_comb begin
        kind   = kind_nop;
        alu_op = op_add;
        casez (opcode)
            6'b???100: begin
                kind   = kind_alu_imm;
                alu_op = alu_op_t'(opcode[5:3]);
            end
            6'b???11?: kind = kind_jal;
            6'b111001: begin
                // Op 000 of the register group is NOR and stays unsupported
                if (group[5:3] == 3'b000 && group[2:0] != 3'b000) begin
                    kind   = kind_alu_reg;
                    alu_op = alu_op_t'(group[2:0]);
                end
            end
            6'b111011: kind = kind_load;
            6'b100010: kind = kind_store;
            6'b111101: kind = kind_beq;
            6'b110101: kind = kind_bne;
            6'b101001: begin
                if (group[5:2] == `LIMN_HALT_GROUP) begin
                    kind = kind_halt;
                end
            end
            default: kind = kind_nop;
        endcase
    end

    assign use_imm = (kind == kind_alu_imm);

endmodule

// File: logic/limn_sequencer.sv
`timescale 1ns/1ps
`include "limn_settings.svh"

module limn_sequencer import limn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output word_t       addr,
    output word_t       data_out,
    input  word_t       data_in,
    output logic        we,
    output logic        cs,
    input  logic        rdy,
    output logic        halted,
    output word_t       instr,
    input  instr_kind_t kind,
    input  reg_idx_t    rd,
    input  reg_idx_t    ra,
    input  reg_idx_t    rb,
    input  word_t       imm16,
    input  word_t       branch_offset,
    input  word_t       jump_target,
    input  word_t       rd_val,
    input  word_t       ra_val,
    input  word_t       alu_result,
    output logic        wr_en,
    output reg_idx_t    wr_idx,
    output word_t       wr_data
);

    core_state_t state;
    word_t       pc;
    word_t       pc_plus4;
    word_t       mem_offset;
    logic        taken;
    logic        fetch_done;

    assign pc_plus4   = pc + word_t'(4);
    assign mem_offset = imm16 << 2;     // Word scaled
    assign fetch_done = (state == st_fetch) && cs && rdy;

    // Both branches compare the first register field with zero
    assign taken = (kind == kind_beq && rd_val == '0) ||
                   (kind == kind_bne && rd_val != '0);

    ////////////////////
    // Control state

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_fetch;
            pc     <= `LIMN_RESET_PC;
            cs     <= 1'b0;
            we     <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!cs) begin
                        cs <= 1'b1;         // Start instruction read
                        we <= 1'b0;
                    end else if (rdy) begin
                        cs    <= 1'b0;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    state <= st_fetch;
                    pc    <= pc_plus4;
                    case (kind)
                        kind_load: begin
                            cs    <= 1'b1;
                            state <= st_read;
                        end
                        kind_store: begin
                            cs    <= 1'b1;
                            we    <= 1'b1;
                            state <= st_write;
                        end
                        kind_beq, kind_bne: begin
                            if (taken) begin
                                pc <= pc + branch_offset;
                            end
                        end
                        kind_jal: pc <= {pc[`LIMN_XLEN-1], jump_target[`LIMN_XLEN-2:0]};
                        kind_halt: begin
                            pc     <= pc;
                            halted <= 1'b1;
                            state  <= st_halted;
                        end
                        default: ;
                    endcase
                end
                st_read, st_write: begin
                    if (rdy) begin          // Transfer ends on this edge
                        cs    <= 1'b0;
                        we    <= 1'b0;
                        state <= st_fetch;
                    end
                end
                default: ;                  // Halted until reset
            endcase
        end
    end

    ////////////////////
    // Bus payload and instruction register

    always_ff @(posedge clk) begin
        if (state == st_fetch && !cs) begin
            addr <= pc;
        end
        if (fetch_done) begin
            instr <= data_in;
        end
        if (state == st_execute) begin
            // Load base is ra, store base is rd
            if (kind == kind_load) begin
                addr <= ra_val + mem_offset;
            end else if (kind == kind_store) begin
                addr     <= rd_val + mem_offset;
                data_out <= ra_val;
            end
        end
    end

    // Write-back select
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = rd;
        wr_data = alu_result;
        if (state == st_execute) begin
            if (kind == kind_alu_reg || kind == kind_alu_imm) begin
                wr_en = 1'b1;
            end else if (kind == kind_jal && instr[0]) begin
                wr_en   = 1'b1;
                wr_idx  = reg_idx_t'(`LIMN_LINK_REG);
                wr_data = pc_plus4;         // Link
            end
        end else if (state == st_read && rdy) begin
            wr_en   = 1'b1;
            wr_data = data_in;
        end
    end

    ////////////////////
    // Checks

    a_addr_aligned : assert property (@(posedge clk) disable iff (rst)
        cs |-> (addr[1:0] == 2'b00));

    a_we_needs_cs : assert property (@(posedge clk) disable iff (rst)
        !cs |-> !we);

endmodule

// File: logic/limn_core.sv
`timescale 1ns/1ps

module limn_core import limn_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output word_t addr,
    output word_t data_out,
    input  word_t data_in,
    output logic  we,
    output logic  cs,
    input  logic  rdy,
    output logic  halted
);

    word_t       instr;
    instr_kind_t kind;
    alu_op_t     alu_op;
    reg_idx_t    rd;
    reg_idx_t    ra;
    reg_idx_t    rb;
    word_t       imm16;
    word_t       branch_offset;
    word_t       jump_target;
    logic        use_imm;
    word_t       rd_val;
    word_t       ra_val;
    word_t       rb_val;
    word_t       alu_result;
    logic        wr_en;
    reg_idx_t    wr_idx;
    word_t       wr_data;

    limn_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .addr          (addr),
        .data_out      (data_out),
        .data_in       (data_in),
        .we            (we),
        .cs            (cs),
        .rdy           (rdy),
        .halted        (halted),
        .instr         (instr),
        .kind          (kind),
        .rd            (rd),
        .ra            (ra),
        .rb            (rb),
        .imm16         (imm16),
        .branch_offset (branch_offset),
        .jump_target   (jump_target),
        .rd_val        (rd_val),
        .ra_val        (ra_val),
        .alu_result    (alu_result),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data)
    );

    limn_decoder u_decoder (
        .instr         (instr),
        .kind          (kind),
        .alu_op        (alu_op),
        .rd            (rd),
        .ra            (ra),
        .rb            (rb),
        .imm16         (imm16),
        .branch_offset (branch_offset),
        .jump_target   (jump_target),
        .use_imm       (use_imm)
    );

    limn_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rd_idx  (rd),
        .ra_idx  (ra),
        .rb_idx  (rb),
        .rd_val  (rd_val),
        .ra_val  (ra_val),
        .rb_val  (rb_val),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    limn_alu u_alu (
        .op      (alu_op),
        .a       (ra_val),
        .rb_val  (rb_val),
        .imm16   (imm16),
        .use_imm (use_imm),
        .result  (alu_result)
    );

endmodule

// File: verification/limn_core_tb.sv
`timescale 1ns/1ps
`include "limn_settings.svh"

module limn_core_tb import limn_pkg::*; ();

    localparam int    MEM_WORDS = 1024;
    localparam word_t DATA_BASE = 32'h0000_0800;

    logic  clk;
    logic  rst;
    word_t addr;
    word_t data_out;
    word_t data_in;
    logic  we;
    logic  cs;
    logic  rdy;
    logic  halted;

    word_t image [MEM_WORDS];   // Program and data as loaded
    word_t mem   [MEM_WORDS];   // Live memory behind the bus
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t rng_state;
    string test_name;
    int    prog_len;
    int    errors;
    int    checks;
    int    tests;
    int    stores_seen;
    logic  watch_on;
    int    watch_cycles;
    int    watch_limit;
    logic  pending;
    int    wait_left;

    limn_core DUT (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .data_out (data_out),
        .data_in  (data_in),
        .we       (we),
        .cs       (cs),
        .rdy      (rdy),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Helpers

    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int mem_index(input word_t a);
        return int'(a[11:2]);   // Low address bits only
    endfunction

    function automatic word_t enc_imm(input alu_op_t op, input reg_idx_t rd,
                                      input reg_idx_t ra, input logic [15:0] imm);
        return {imm, ra, rd, op, 3'b100};
    endfunction

    function automatic word_t enc_reg(input alu_op_t op, input reg_idx_t rd,
                                      input reg_idx_t ra, input reg_idx_t rb);
        return {3'b000, op, 5'd0, rb, ra, rd, 6'b111001};
    endfunction

    function automatic word_t enc_load(input reg_idx_t rd, input reg_idx_t base,
                                       input logic [15:0] imm);
        return {imm, base, rd, 6'b111011};
    endfunction

    // Base sits in the first register field, value in the second
    function automatic word_t enc_store(input reg_idx_t base, input reg_idx_t val,
                                        input logic [15:0] imm);
        return {imm, val, base, 6'b100010};
    endfunction

    function automatic word_t enc_branch(input logic is_beq, input reg_idx_t rd,
                                         input int words);
        return {21'(words), rd, (is_beq ? 6'b111101 : 6'b110101)};
    endfunction

    function automatic word_t enc_jal(input word_t target, input logic link);
        return {target[30:2], 2'b11, link};
    endfunction

    function automatic word_t enc_halt();
        return {4'b1100, 22'd0, 6'b101001};
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            op_or:   return a | b;
            op_slt:  return (a < b) ? 32'd1 : 32'd0;
            op_slts: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a | (b << 16);     // LUI
        endcase
    endfunction

    ////////////////////
    // Reference interpreter

    // Fills the expected store list, returns the instruction count
    function automatic int run_reference();
        word_t      dmem [MEM_WORDS];
        word_t      r [32];
        word_t      pc;
        word_t      w;
        word_t      a;
        word_t      ea;
        word_t      next_pc;
        logic [5:0] op;
        reg_idx_t   rd_i;
        int         off;
        int         count;
        logic       done;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = image[i];
        end
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = `LIMN_RESET_PC;
        count = 0;
        done = 1'b0;
        while (!done && count < 2000) begin
            w = dmem[mem_index(pc)];
            op = w[5:0];
            rd_i = w[10:6];
            a = r[w[15:11]];
            next_pc = pc + 32'd4;
            count++;
            if (op[2:0] == 3'b100) begin
                r[rd_i] = alu_ref(alu_op_t'(op[5:3]), a, word_t'(w[31:16]));
            end else if (op[2:1] == 2'b11) begin
                if (w[0]) begin
                    r[`LIMN_LINK_REG] = pc + 32'd4;
                end
                next_pc = {pc[31], w[31:3], 2'b00};
            end else if (op == 6'b111001) begin
                if (w[31:29] == 3'b000 && w[28:26] != 3'b000) begin
                    r[rd_i] = alu_ref(alu_op_t'(w[28:26]), a, r[w[20:16]]);
                end
            end else if (op == 6'b111011) begin
                r[rd_i] = dmem[mem_index(a + (word_t'(w[31:16]) << 2))];
            end else if (op == 6'b100010) begin
                ea = r[rd_i] + (word_t'(w[31:16]) << 2);
                dmem[mem_index(ea)] = a;
                exp_addr.push_back(ea);
                exp_data.push_back(a);
            end else if (op == 6'b111101 || op == 6'b110101) begin
                off = $signed(w[31:11]);
                if ((r[rd_i] == '0) == (op == 6'b111101)) begin
                    next_pc = pc + off * 4;
                end
            end else if (op == 6'b101001 && w[31:28] == 4'b1100) begin
                done = 1'b1;
            end
            r[0] = '0;
            pc = next_pc;
        end
        return count;
    endfunction

    ////////////////////
    // Checks

    task automatic check_addr(input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s store address expected %h actual %h",
                     test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s store data expected %h actual %h",
                     test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_halted(input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s halted expected %b actual %b", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_cs(input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("MISMATCH %s bus select expected %b actual %b", test_name, expected, actual);
            errors++;
        end
    endtask

    ////////////////////
    // Memory model and monitors

    // rdy comes 0 to 3 cycles after cs rises
    always @(negedge clk) begin
        if (!cs) begin
            rdy = 1'b0;
            pending = 1'b0;
        end else if (!rdy) begin
            if (!pending) begin
                pending = 1'b1;
                wait_left = int'(next_random() % 4);
            end else begin
                wait_left--;
            end
            if (wait_left == 0) begin
                rdy = 1'b1;
                if (we) begin
                    mem[mem_index(addr)] = data_out;
                end else begin
                    data_in = mem[mem_index(addr)];
                end
            end
        end
    end

    // Store transfers complete on this edge
    always @(posedge clk) begin
        if (!rst && cs && we && rdy) begin
            stores_seen++;
            if (exp_addr.size() == 0) begin
                $display("ERROR %s: store to %h that the reference never made", test_name, addr);
                errors++;
            end else begin
                check_addr(exp_addr.pop_front(), addr);
                check_word(exp_data.pop_front(), data_out);
            end
        end
    end

    always @(posedge clk) begin
        if (watch_on) begin
            watch_cycles++;
            if (watch_cycles > watch_limit) begin
                $display("Timeout: test %s stalled, no halt within %0d cycles",
                         test_name, watch_limit);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    ////////////////////
    // Program loading and test runs

    task automatic clear_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i] = (word_t'(i) * 32'h0101_0107) ^ 32'hA5C3_0F69;
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic poke(input word_t a, input word_t value);
        image[mem_index(a)] = value;
    endtask

    task automatic run_test(input string name);
        int start_errors;
        int count;
        test_name = name;
        start_errors = errors;
        stores_seen = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = image[i];
        end
        count = run_reference();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        check_cs(1'b0, cs);
        check_halted(1'b0, halted);
        // Fetch and data transfer of 4 cycles each, execute, margin
        watch_limit = count * (2 * 4 + 1 + 3) * 2;
        watch_cycles = 0;
        watch_on = 1'b1;
        rst = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        watch_on = 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_cs(1'b0, cs);
            check_halted(1'b1, halted);
        end
        if (exp_addr.size() != 0) begin
            $display("ERROR %s: %0d expected stores never reached the bus",
                     name, exp_addr.size());
            errors++;
        end
        tests++;
        $display("Test %-12s %s: %0d instructions, %0d stores, %0d errors", name,
                 (errors == start_errors) ? "ok" : "FAILED", count, stores_seen,
                 errors - start_errors);
    endtask

    task automatic test_alu_reg();
        alu_op_t ops [7];
        ops = '{op_add, op_sub, op_and, op_xor, op_or, op_slt, op_slts};
        clear_image();
        poke(DATA_BASE + 32'h100, next_random());
        poke(DATA_BASE + 32'h104, next_random());
        poke(DATA_BASE + 32'h108, next_random() | 32'h8000_0000);   // Negative
        poke(DATA_BASE + 32'h10C, next_random() & 32'h7FFF_FFFF);   // Positive
        emit(enc_imm(op_add, 1, 0, 16'h0800));
        for (int k = 0; k < 4; k++) begin
            emit(enc_load(2 + k, 1, 16'h40 + k));
        end
        for (int k = 0; k < 7; k++) begin
            emit(enc_reg(ops[k], 10 + k, 2, 3));
            emit(enc_store(1, 10 + k, k));
        end
        // Mixed signs in both orders
        emit(enc_reg(op_slts, 20, 4, 5));
        emit(enc_reg(op_slts, 21, 5, 4));
        emit(enc_reg(op_slt, 22, 4, 5));
        emit(enc_store(1, 20, 7));
        emit(enc_store(1, 21, 8));
        emit(enc_store(1, 22, 9));
        emit(enc_halt());
        run_test("alu_reg");
    endtask

    task automatic test_alu_imm();
        clear_image();
        emit(enc_imm(op_add, 1, 0, 16'h0800));
        emit(enc_imm(op_lui, 2, 0, 16'h1234));
        emit(enc_imm(op_or, 2, 2, 16'h5678));
        emit(enc_imm(op_xor, 3, 2, 16'hFFFF));
        emit(enc_imm(op_and, 4, 2, 16'h0FF0));
        emit(enc_imm(op_sub, 5, 2, 16'h0001));
        emit(enc_imm(op_lui, 6, 4, 16'hBEEF));     // Keeps the low half of r4
        emit(enc_imm(op_slt, 7, 4, 16'h0FFF));
        emit(enc_imm(op_slts, 8, 2, 16'h8000));
        emit(enc_imm(op_add, 0, 0, 16'h0055));
        emit(enc_imm(op_lui, 0, 2, 16'hFFFF));
        for (int k = 0; k < 8; k++) begin
            emit(enc_store(1, (k == 7) ? 0 : 2 + k, k));
        end
        emit(enc_halt());
        run_test("alu_imm");
    endtask

    task automatic test_load_store();
        clear_image();
        emit(enc_imm(op_add, 1, 0, 16'h0800));
        for (int k = 0; k < 6; k++) begin
            poke(DATA_BASE + 32'h100 + 4 * k, next_random());
            emit(enc_load(2 + k, 1, 16'h40 + k));
        end
        for (int k = 0; k < 6; k++) begin
            emit(enc_store(1, 2 + k, 16'h80 + k));
        end
        // Read back a word the core wrote itself
        emit(enc_load(10, 1, 16'h80));
        emit(enc_store(1, 10, 16'h90));
        emit(enc_halt());
        run_test("load_store");
    endtask

    task automatic test_branches();
        clear_image();
        emit(enc_imm(op_add, 1, 0, 16'h0800));          // 0
        emit(enc_imm(op_add, 2, 0, 16'h0001));
        emit(enc_branch(1'b1, 0, 2));                   // 2 taken
        emit(enc_store(1, 2, 0));
        emit(enc_imm(op_add, 3, 0, 16'h0011));          // 4
        emit(enc_store(1, 3, 1));
        emit(enc_branch(1'b1, 2, 2));                   // 6 not taken
        emit(enc_imm(op_add, 3, 0, 16'h0022));
        emit(enc_store(1, 3, 2));                       // 8
        emit(enc_branch(1'b0, 0, 5));                   // Not taken
        emit(enc_branch(1'b0, 2, 3));                   // 10 taken
        emit(enc_imm(op_add, 3, 0, 16'h00EE));
        emit(enc_store(1, 3, 3));                       // 12
        emit(enc_jal(`LIMN_RESET_PC + 32'd64, 1'b1));   // Link to r31
        emit(enc_imm(op_add, 3, 0, 16'h00DD));
        emit(enc_store(1, 3, 3));
        emit(enc_store(1, 31, 4));                      // 16
        emit(enc_imm(op_add, 4, 0, 16'h0002));
        emit(enc_store(1, 4, 5));                       // 18 loop head
        emit(enc_imm(op_sub, 4, 4, 16'h0001));
        emit(enc_branch(1'b0, 4, -2));                  // 20 backward
        emit(enc_jal(`LIMN_RESET_PC + 32'd92, 1'b0));
        emit(enc_store(1, 2, 6));                       // 22
        emit(enc_store(1, 31, 7));                      // r31 unchanged
        emit(enc_halt());
        run_test("branches");
    endtask

    task automatic test_halt();
        clear_image();
        emit(32'h0000_0005);    // Unsupported opcodes advance pc only
        emit(32'h1234_0001);
        emit(32'h0000_0039);
        emit(32'h0000_0029);
        emit(enc_imm(op_add, 1, 0, 16'h0800));
        emit(enc_imm(op_add, 2, 0, 16'h0077));
        emit(enc_store(1, 2, 0));
        emit(enc_halt());
        run_test("halt");
    endtask

    ////////////////////
    // Main sequence

    initial begin
        rst = 1'b1;
        rdy = 1'b0;
        data_in = '0;
        rng_state = 32'd31;
        errors = 0;
        checks = 0;
        tests = 0;
        stores_seen = 0;
        watch_on = 1'b0;
        watch_cycles = 0;
        watch_limit = 0;
        pending = 1'b0;
        wait_left = 0;
        test_name = "none";
        test_alu_reg();
        test_alu_imm();
        test_load_store();
        test_branches();
        test_halt();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
logic/limn_pkg.sv
logic/limn_alu.sv
logic/limn_regfile.sv
logic/limn_decoder.sv
logic/limn_sequencer.sv
logic/limn_core.sv
verification/limn_core_tb.sv
